// ==== include/bus_settings.svh ====
`ifndef BUS_SETTINGS_SVH
`define BUS_SETTINGS_SVH

// bus widths, one address is one word-aligned byte address
`define BUS_AW 16
`define BUS_DW 32

// number of real slaves, the none-selected slot comes on top
`define BUS_NS 3

// slave windows, slave 0 in the low word
// base 0x0000, 0x1000 and 0x2000, everything from 0x3000 up is unmapped
`define BUS_SLAVE_ADDR {16'h2000, 16'h1000, 16'h0000}

// each window is decided by the top four address bits
`define BUS_SLAVE_MASK {16'hf000, 16'hf000, 16'hf000}

// slave 2 is write protected
`define BUS_WRITE_ALLOWED 3'b011

// 1 gives the registered decoder, 0 the combinational one
`define BUS_REGISTERED 1

// words per RAM slave, word index from address bits 5:2
`define BUS_RAM_WORDS 16

// response FIFO depth, also the in-flight limit
`define BUS_RSP_DEPTH 4

`endif

// ==== hw/bus_pkg.sv ====
`include "bus_settings.svh"

package bus_pkg;

	// one bus address
	typedef logic [`BUS_AW-1:0] bus_addr_t;

	// one data word
	typedef logic [`BUS_DW-1:0] bus_data_t;

	// byte enables, one per byte lane
	typedef logic [`BUS_DW/8-1:0] bus_sel_t;

	// request as it travels from the master down to the slaves
	typedef struct packed {
		// write enable
		logic we;
		// byte lanes touched by a write
		bus_sel_t sel;
		bus_addr_t addr;
		bus_data_t wdata;
	} bus_req_t;

	// one response per request, returned in order
	typedef struct packed {
		// set for unmapped addresses and denied writes
		logic err;
		// read data, zero on writes and errors
		bus_data_t rdata;
	} bus_rsp_t;

	// one-hot slave select
	// top bit is the none-selected slot
	typedef logic [`BUS_NS:0] bus_decode_t;

endpackage

// ==== hw/bus_req_stage.sv ====
`include "bus_settings.svh"

module bus_req_stage (
	input  logic              i_clk,
	input  logic              i_reset,
	input  logic              i_valid,
	output logic              o_stall,
	input  bus_pkg::bus_req_t i_req,
	output logic              o_valid,
	input  logic              i_stall,
	output bus_pkg::bus_req_t o_req
);
	import bus_pkg::*;

	// spare entry, filled while the output is held
	bus_req_t skid_req;
	logic accept;
	logic out_free;

	// o_stall doubles as the spare entry full flag
	assign accept = i_valid && !o_stall;

	// output register can take a new word this cycle
	assign out_free = !o_valid || !i_stall;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_valid <= 1'b0;
			o_stall <= 1'b0;
		end
		else if (out_free)
		begin
			// spare drains first, otherwise take the master directly
			o_valid <= o_stall || accept;
			o_stall <= 1'b0;
		end
		else if (accept)
		begin
			// output held, park the new request in the spare entry
			o_stall <= 1'b1;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (out_free)
			o_req <= o_stall ? skid_req : i_req;
		if (!out_free && accept)
			skid_req <= i_req;
	end

	// spare entry only fills behind a held output word
	assert property (@(posedge i_clk) disable iff (i_reset)
		o_stall |-> o_valid);

	// a request taken behind a held output word lands in the spare entry
	// the held word itself stays untouched
	assert property (@(posedge i_clk) disable iff (i_reset)
		(accept && o_valid && i_stall) |=> (o_stall && $stable(o_req)
			&& (skid_req == $past(i_req))));

endmodule

// ==== hw/bus_addr_decode.sv ====
`include "bus_settings.svh"

module bus_addr_decode #(
	parameter type payload_t = logic
) (
	input  logic                 i_clk,
	input  logic                 i_reset,
	input  logic                 i_valid,
	output logic                 o_stall,
	input  bus_pkg::bus_addr_t   i_addr,
	input  logic                 i_we,
	input  payload_t             i_data,
	output logic                 o_valid,
	input  logic                 i_stall,
	output bus_pkg::bus_decode_t o_decode,
	output payload_t             o_data
);
	import bus_pkg::*;

	localparam int NS = `BUS_NS;
	localparam int AW = `BUS_AW;
	localparam logic [NS*AW-1:0] SLAVE_ADDR = `BUS_SLAVE_ADDR;
	localparam logic [NS*AW-1:0] SLAVE_MASK = `BUS_SLAVE_MASK;
	localparam logic [NS-1:0] WRITE_ALLOWED = `BUS_WRITE_ALLOWED;
	localparam bit REGISTERED = `BUS_REGISTERED;

	// per slave window match including write permission
	logic [NS-1:0] hit;
	// decode of the current input, gated by i_valid
	bus_decode_t request;

	// address bits under the mask must equal the base
	// writes also need the slave's write-allow bit
	always_comb
	begin
		for (int k = 0; k < NS; k++)
		begin
			hit[k] = (((i_addr ^ SLAVE_ADDR[k*AW +: AW])
				& SLAVE_MASK[k*AW +: AW]) == '0)
				&& (!i_we || WRITE_ALLOWED[k]);
		end
	end

	always_comb
	begin
		request[NS-1:0] = hit & {NS{i_valid}};
		// nothing matched, so the none-selected slot answers with an error
		// a denied write lands here as well
		request[NS] = i_valid && (hit == '0);
	end

	if (REGISTERED)
	begin : g_registered
		// new input taken while the output is free or being consumed
		logic take_new;

		assign take_new = i_valid && (!o_valid || !i_stall);

		// stall only while a valid output is held
		assign o_stall = o_valid && i_stall;

		always_ff @(posedge i_clk)
		begin
			if (i_reset)
				o_valid <= 1'b0;
			else if (!o_stall)
				o_valid <= i_valid;
		end

		always_ff @(posedge i_clk)
		begin
			if (i_reset)
				o_decode <= '0;
			else if (take_new)
				o_decode <= request;
			else if (!i_stall)
				// consumed with nothing behind it, drop the select
				o_decode <= '0;
		end

		always_ff @(posedge i_clk)
		begin
			if (take_new)
				o_data <= i_data;
			else if (!i_stall)
				o_data <= '0;
		end
	end
	else
	begin : g_comb
		// straight through, decode in the same cycle
		assign o_valid = i_valid;
		assign o_stall = i_stall;
		assign o_decode = request;
		assign o_data = i_data;
	end

	// exactly one slot answers each request, error slot included
	assert property (@(posedge i_clk) disable iff (i_reset)
		o_valid |-> $onehot(o_decode));

endmodule

// ==== hw/bus_slave_ram.sv ====
`include "bus_settings.svh"

module bus_slave_ram (
	input  logic               i_clk,
	input  logic               i_reset,
	input  logic               i_stb,
	input  bus_pkg::bus_req_t  i_req,
	output logic               o_ack,
	output bus_pkg::bus_data_t o_rdata
);
	import bus_pkg::*;

	localparam int WORDS = `BUS_RAM_WORDS;
	localparam int IW = $clog2(WORDS);
	localparam int NB = `BUS_DW / 8;

	bus_data_t mem [WORDS];
	// word index, byte offset bits dropped
	logic [IW-1:0] idx;

	assign idx = i_req.addr[IW+1:2];

	// memory starts out zero so reads before any write are defined
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			for (int w = 0; w < WORDS; w++)
				mem[w] <= '0;
		end
		else if (i_stb && i_req.we)
		begin
			// only the enabled byte lanes change
			for (int b = 0; b < NB; b++)
			begin
				if (i_req.sel[b])
					mem[idx][8*b +: 8] <= i_req.wdata[8*b +: 8];
			end
		end
	end

	// every strobe is answered on the next cycle
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_ack <= 1'b0;
		else
			o_ack <= i_stb;
	end

	// read data is the word before any write in the same cycle
	// writes answer with zero
	always_ff @(posedge i_clk)
	begin
		if (i_stb)
			o_rdata <= i_req.we ? '0 : mem[idx];
	end

endmodule

// ==== hw/bus_rsp_mux.sv ====
`include "bus_settings.svh"

module bus_rsp_mux (
	input  logic                                i_clk,
	input  logic                                i_reset,
	input  logic                                i_valid,
	output logic                                o_stall,
	input  bus_pkg::bus_decode_t                i_decode,
	input  bus_pkg::bus_req_t                   i_req,
	output logic [`BUS_NS-1:0]                  o_stb,
	output bus_pkg::bus_req_t                   o_req,
	input  logic [`BUS_NS-1:0]                  i_ack,
	input  bus_pkg::bus_data_t [`BUS_NS-1:0]    i_rdata,
	output logic                                o_rsp_valid,
	input  logic                                i_rsp_stall,
	output bus_pkg::bus_rsp_t                   o_rsp
);
	import bus_pkg::*;

	localparam int NS = `BUS_NS;
	localparam int DEPTH = `BUS_RSP_DEPTH;
	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);
	localparam logic [CW-1:0] DEPTH_C = CW'(DEPTH);
	localparam logic [PW-1:0] LAST_C = PW'(DEPTH - 1);

	logic accept;
	logic take;
	logic fifo_wr;
	logic fifo_rd;
	// slot strobed last cycle, answers now
	bus_decode_t ans_slot;
	bus_data_t rdata_sel;
	bus_rsp_t rsp_in;
	bus_rsp_t fifo_mem [DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] fifo_cnt;
	// accepted requests not yet taken by the master
	logic [CW-1:0] pending;

	// stop taking requests once every FIFO slot is spoken for
	assign o_stall = (pending == DEPTH_C);
	assign accept = i_valid && !o_stall;

	// strobe goes out in the accept cycle, the none slot has no strobe
	assign o_stb = i_decode[NS-1:0] & {NS{accept}};
	assign o_req = i_req;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			ans_slot <= '0;
		else if (accept)
			ans_slot <= i_decode;
		else
			ans_slot <= '0;
	end

	// and-or pick of the answering slave's data
	// error slot has no slave bit, so rdata stays zero
	always_comb
	begin
		rdata_sel = '0;
		for (int k = 0; k < NS; k++)
		begin
			if (ans_slot[k])
				rdata_sel = rdata_sel | i_rdata[k];
		end
	end

	assign rsp_in.err = ans_slot[NS];
	assign rsp_in.rdata = rdata_sel;

	// slave acks plus the none slot, which answers on its own
	assign fifo_wr = (|i_ack) || ans_slot[NS];

	// refill the output register when it is empty or being taken
	assign fifo_rd = (fifo_cnt != '0) && (!o_rsp_valid || !i_rsp_stall);
	assign take = o_rsp_valid && !i_rsp_stall;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_cnt <= '0;
			pending <= '0;
		end
		else
		begin
			if (fifo_wr)
				wr_ptr <= (wr_ptr == LAST_C) ? '0 : wr_ptr + 1'b1;
			if (fifo_rd)
				rd_ptr <= (rd_ptr == LAST_C) ? '0 : rd_ptr + 1'b1;
			fifo_cnt <= fifo_cnt + CW'(fifo_wr) - CW'(fifo_rd);
			pending <= pending + CW'(accept) - CW'(take);
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (fifo_wr)
			fifo_mem[wr_ptr] <= rsp_in;
		if (fifo_rd)
			o_rsp <= fifo_mem[rd_ptr];
	end

	// output register, held while the master stalls
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_rsp_valid <= 1'b0;
		else if (!o_rsp_valid || !i_rsp_stall)
			o_rsp_valid <= (fifo_cnt != '0);
	end

	// slaves only answer the strobe of the cycle before
	assert property (@(posedge i_clk) disable iff (i_reset)
		(|i_ack) |-> (i_ack == $past(o_stb)));

	// the in-flight limit keeps the FIFO from ever being written when full
	assert property (@(posedge i_clk) disable iff (i_reset)
		fifo_wr |-> (fifo_cnt != DEPTH_C));

endmodule

// ==== hw/bus_xbar_top.sv ====
`include "bus_settings.svh"

module bus_xbar_top (
	input  logic              i_clk,
	input  logic              i_reset,
	input  logic              i_req_valid,
	output logic              o_req_stall,
	input  bus_pkg::bus_req_t i_req,
	output logic              o_rsp_valid,
	input  logic              i_rsp_stall,
	output bus_pkg::bus_rsp_t o_rsp
);
	import bus_pkg::*;

	localparam int NS = `BUS_NS;

	// skid stage to decoder
	logic stage_valid;
	logic stage_stall;
	bus_req_t stage_req;

	// decoder to response side
	logic dec_valid;
	logic dec_stall;
	bus_decode_t dec_sel;
	bus_req_t dec_req;

	// response side to slaves and back
	logic [NS-1:0] slave_stb;
	bus_req_t slave_req;
	logic [NS-1:0] slave_ack;
	bus_data_t [NS-1:0] slave_rdata;

	bus_req_stage req_stage_i (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_valid (i_req_valid),
		.o_stall (o_req_stall),
		.i_req   (i_req),
		.o_valid (stage_valid),
		.i_stall (stage_stall),
		.o_req   (stage_req)
	);

	// whole request rides along as the decoder payload
	bus_addr_decode #(
		.payload_t (bus_req_t)
	) addr_decode_i (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_valid  (stage_valid),
		.o_stall  (stage_stall),
		.i_addr   (stage_req.addr),
		.i_we     (stage_req.we),
		.i_data   (stage_req),
		.o_valid  (dec_valid),
		.i_stall  (dec_stall),
		.o_decode (dec_sel),
		.o_data   (dec_req)
	);

	for (genvar k = 0; k < NS; k++)
	begin : g_slave
		bus_slave_ram slave_ram_i (
			.i_clk   (i_clk),
			.i_reset (i_reset),
			.i_stb   (slave_stb[k]),
			.i_req   (slave_req),
			.o_ack   (slave_ack[k]),
			.o_rdata (slave_rdata[k])
		);
	end

	bus_rsp_mux rsp_mux_i (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_valid     (dec_valid),
		.o_stall     (dec_stall),
		.i_decode    (dec_sel),
		.i_req       (dec_req),
		.o_stb       (slave_stb),
		.o_req       (slave_req),
		.i_ack       (slave_ack),
		.i_rdata     (slave_rdata),
		.o_rsp_valid (o_rsp_valid),
		.i_rsp_stall (i_rsp_stall),
		.o_rsp       (o_rsp)
	);

endmodule

// ==== tb/tb_clk_gen.sv ====
module tb_clk_gen (
	output logic o_clk,
	output logic o_reset
);
	timeunit 1ns;
	timeprecision 100ps;

	// 10 ns period
	initial
	begin
		o_clk = 1'b0;
		forever #5 o_clk = ~o_clk;
	end

	// reset held for 16 rising edges, released just after the edge
	initial
	begin
		o_reset = 1'b1;
		repeat (16) @(posedge o_clk);
		#1 o_reset = 1'b0;
	end

endmodule

// ==== tb/tb_bus_xbar.sv ====
`include "bus_settings.svh"

module tb_bus_xbar;
	timeunit 1ns;
	timeprecision 100ps;
	import bus_pkg::*;

	// about 700 requests, worst case 25 cycles each with 50% response stall and drain gaps
	localparam int TEST_REQS = 700;
	localparam int MAX_CYCLES = TEST_REQS * 25 + 2500;

	logic i_clk;
	logic i_reset;
	logic i_req_valid;
	logic o_req_stall;
	bus_req_t i_req;
	logic o_rsp_valid;
	logic i_rsp_stall;
	bus_rsp_t o_rsp;

	// shadow copy of every RAM slave
	bus_data_t shadow [`BUS_NS][`BUS_RAM_WORDS];
	bus_rsp_t exp_q [$];
	bus_rsp_t exp_r;
	string test_name;
	int errors = 0;
	int passes = 0;
	int acc_count = 0;
	int rsp_count = 0;
	int cycles = 0;
	int test_errors;
	bit rand_stall = 0;
	bit hold_stall = 0;
	bit saw_req_stall = 0;

	tb_clk_gen clk_gen_i (
		.o_clk   (i_clk),
		.o_reset (i_reset)
	);

	bus_xbar_top dut_i (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_req_valid (i_req_valid),
		.o_req_stall (o_req_stall),
		.i_req       (i_req),
		.o_rsp_valid (o_rsp_valid),
		.i_rsp_stall (i_rsp_stall),
		.o_rsp       (o_rsp)
	);

	// expected response from the address map, write mask and byte enables
	// writes that land also update the shadow RAM
	function automatic bus_rsp_t model_rsp(input bus_req_t r);
		bus_rsp_t rsp;
		int slot;
		int word;
		logic [`BUS_NS-1:0] wr_ok;
		wr_ok = `BUS_WRITE_ALLOWED;
		rsp = '0;
		slot = int'(r.addr[15:12]);
		word = int'(r.addr[5:2]);
		if (slot >= `BUS_NS)
			rsp.err = 1'b1;
		else if (r.we && !wr_ok[slot])
			rsp.err = 1'b1;
		else if (r.we)
		begin
			for (int b = 0; b < `BUS_DW / 8; b++)
			begin
				if (r.sel[b])
					shadow[slot][word][8*b +: 8] = r.wdata[8*b +: 8];
			end
		end
		else
			rsp.rdata = shadow[slot][word];
		return rsp;
	endfunction

	function automatic bus_req_t make_req(input logic we, input logic [3:0] sel,
		input logic [15:0] addr, input logic [31:0] wdata);
		bus_req_t r;
		r.we = we;
		r.sel = sel;
		r.addr = addr;
		r.wdata = wdata;
		return r;
	endfunction

	// top nibble 0..4, so slots 3 and 4 hit unmapped space
	function automatic bus_req_t random_req();
		logic [3:0] slot;
		slot = 4'($urandom % 5);
		return make_req(1'($urandom), 4'($urandom), {slot, 12'($urandom)}, $urandom);
	endfunction

	// drive one request and hold it until the skid stage takes it
	task automatic send(input bus_req_t r);
		@(posedge i_clk);
		#1;
		i_req_valid = 1'b1;
		i_req = r;
		@(negedge i_clk);
		while (o_req_stall)
			@(negedge i_clk);
		// stall is low, so the coming edge accepts it
		exp_q.push_back(model_rsp(r));
		acc_count++;
	endtask

	task automatic idle_cycle();
		@(posedge i_clk);
		#1;
		i_req_valid = 1'b0;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = errors;
	endtask

	// wait for all responses, then a few cycles to catch any extra one
	task automatic finish_test();
		idle_cycle();
		while (exp_q.size() != 0)
			@(posedge i_clk);
		repeat (6) @(posedge i_clk);
		if (rsp_count != acc_count)
		begin
			errors++;
			$display("%s: %0d responses for %0d accepted requests", test_name,
				rsp_count, acc_count);
		end
		$display("test %s finished, %0d errors", test_name, errors - test_errors);
	endtask

	// response stall, driven 1 ns after the edge
	initial
	begin
		i_rsp_stall = 1'b0;
		forever
		begin
			@(posedge i_clk);
			#1;
			i_rsp_stall = hold_stall || (rand_stall && ($urandom % 2 == 1));
		end
	end

	// a response is taken on the next edge, so compare it mid-cycle
	always @(negedge i_clk)
	begin
		if (!i_reset && o_rsp_valid && !i_rsp_stall)
		begin
			rsp_count++;
			if (exp_q.size() == 0)
			begin
				errors++;
				$display("%s: response arrived with no request outstanding", test_name);
			end
			else
			begin
				exp_r = exp_q.pop_front();
				if (o_rsp !== exp_r)
				begin
					errors++;
					$display("Mismatch %s: expected err=%0b rdata=%h, actual err=%0b rdata=%h",
						test_name, exp_r.err, exp_r.rdata, o_rsp.err, o_rsp.rdata);
				end
				else
					passes++;
			end
		end
		if (o_req_stall)
			saw_req_stall = 1'b1;
	end

	always @(posedge i_clk)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout waiting for responses");
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial
	begin
		void'($urandom(10248));
		i_req_valid = 1'b0;
		i_req = '0;
		for (int s = 0; s < `BUS_NS; s++)
			for (int w = 0; w < `BUS_RAM_WORDS; w++)
				shadow[s][w] = '0;
		@(negedge i_reset);
		@(posedge i_clk);
		#1;

		start_test("reset_rw");
		if (o_rsp_valid || o_req_stall)
		begin
			errors++;
			$display("%s: rsp valid or req stall high after reset", test_name);
		end
		// write then read each slave, slave 2 rejects the write
		for (int s = 0; s < `BUS_NS; s++)
		begin
			send(make_req(1'b1, 4'hf, 16'(s * 16'h1000 + 4), 32'hc0de_0000 + s));
			send(make_req(1'b0, 4'h0, 16'(s * 16'h1000 + 4), '0));
		end
		finish_test();

		start_test("byte_enables");
		for (int i = 0; i < 40; i++)
			send(make_req(1'b1, 4'($urandom), {4'(i % 2), 12'($urandom)}, $urandom));
		// read every word of slaves 0 and 1 back
		for (int i = 0; i < 2 * `BUS_RAM_WORDS; i++)
			send(make_req(1'b0, 4'h0, {4'(i / 16), 6'h0, 4'(i % 16), 2'b00}, '0));
		finish_test();

		start_test("unmapped");
		for (int i = 0; i < 16; i++)
			send(make_req(1'($urandom), 4'hf, 16'h3000 + 16'($urandom % 16'hd000),
				$urandom));
		finish_test();

		start_test("write_protect");
		for (int i = 0; i < 8; i++)
			send(make_req(1'b1, 4'hf, {4'h2, 12'($urandom)}, $urandom));
		for (int i = 0; i < 8; i++)
			send(make_req(1'b0, 4'h0, {4'h2, 12'($urandom)}, '0));
		finish_test();

		start_test("random_mix");
		rand_stall = 1'b1;
		for (int i = 0; i < 600; i++)
		begin
			send(random_req());
			if ($urandom % 4 == 0)
				idle_cycle();
		end
		finish_test();
		rand_stall = 1'b0;

		start_test("held_stall");
		saw_req_stall = 1'b0;
		hold_stall = 1'b1;
		fork
			for (int i = 0; i < 12; i++)
				send(random_req());
			begin
				repeat (20) @(posedge i_clk);
				hold_stall = 1'b0;
			end
		join
		finish_test();
		if (!saw_req_stall)
		begin
			errors++;
			$display("%s: request stall never rose while responses were held", test_name);
		end

		$display("done: %0d checks passed, %0d errors", passes, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== bus_xbar_top.f ====
+incdir+include
hw/bus_pkg.sv
hw/bus_req_stage.sv
hw/bus_addr_decode.sv
hw/bus_slave_ram.sv
hw/bus_rsp_mux.sv
hw/bus_xbar_top.sv
tb/tb_clk_gen.sv
tb/tb_bus_xbar.sv
